//--- verif/correlator_vectors.txt
# s count x0_re x0_im x1_re x1_im sync valid | l acc_len | c | w cycles | f data_ready ovf_flag
# r sel addr expected, sel 0 r11 1 r22 2 r12_re 3 r12_im
# single frame, acc_len 1
l 1
s 1 1 2 3 4 1 1
s 1 -5 6 7 -8 0 1
s 1 10 -3 2 5 0 1
s 4 0 0 0 0 0 1
s 1 -7 2 4 -9 0 1
w 8
f 1 0
r 0 0 5
r 1 0 25
r 2 0 11
r 3 0 2
r 2 1 -83
r 3 2 -56
r 0 5 0
r 3 7 -55
f 0 0
# three frames with gaps in din_valid
l 3
s 8 2 -1 3 1 1 1
w 2
s 5 -4 3 0 2 0 1
w 3
s 3 -4 3 0 2 0 1
s 2 6 5 -2 -3 0 0
s 8 6 5 -2 -3 0 1
w 8
f 1 0
r 0 0 91
r 1 5 27
r 2 3 -16
r 3 7 11
# next integration runs on without sync and reloads on its first frame
s 24 1 0 0 1 0 1
w 8
f 1 0
r 0 2 3
r 1 6 3
r 3 4 -3
# full scale over four frames, sums still fit in 32 bits
l 4
s 32 -128 -128 -128 127 1 1
w 8
f 1 0
r 0 3 131072
r 1 3 130052
r 2 0 512
r 3 7 130560
# cnt_rst mid frame, samples dropped until the next sync
l 2
s 4 5 5 5 5 1 1
c
s 4 9 9 9 9 0 1
l 1
s 8 1 -2 -3 4 1 1
w 8
f 1 0
r 0 6 5
r 2 3 -11
r 3 7 2
f 0 0

//--- sim.f
logic/corr_pkg.sv
logic/frame_control.sv
logic/power_mult.sv
logic/vector_accumulator.sv
logic/correlator_lane.sv
logic/result_bank.sv
logic/correlator_top.sv
verif/correlator_tb.sv

//--- verif/correlator_tb.sv
`timescale 1ns/1ps
`default_nettype none

module correlator_tb;
    import corr_pkg::*;

    logic clk = 1'b0;
    logic reset;
    cplx_pair_t din;
    logic din_valid;
    logic sync_in;
    acc_len_t acc_len;
    logic cnt_rst;
    logic rd_en;
    chan_t rd_addr;
    sel_t rd_sel;
    acc_t rd_data;
    logic rd_valid;
    logic data_ready;
    logic ovf_flag;

    int acc_errors = 0;
    int flag_errors = 0;
    int other_errors = 0;
    int cycle_cnt = 0;
    // final value comes from the vector line count
    int cycle_limit = 200;
    int line_cnt = 0;

    int fd;
    int n;
    int count;
    int v0;
    int v1;
    int v2;
    int v3;
    int sync;
    int valid;
    logic [8*8-1:0] op;
    logic [8*128-1:0] skip_line;
    cplx_pair_t pair;

    correlator_top dut0 (
        .clk(clk),
        .reset(reset),
        .din(din),
        .din_valid(din_valid),
        .sync_in(sync_in),
        .acc_len(acc_len),
        .cnt_rst(cnt_rst),
        .rd_en(rd_en),
        .rd_addr(rd_addr),
        .rd_sel(rd_sel),
        .rd_data(rd_data),
        .rd_valid(rd_valid),
        .data_ready(data_ready),
        .ovf_flag(ovf_flag)
    );

    always #2 clk = ~clk;

    task automatic check_acc(input string name, input acc_t got, input acc_t expected);
        if (got !== expected) begin
            acc_errors++;
            $display("error at %0t ns: %s is %0d, expected %0d", $time, name, got, expected);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            flag_errors++;
            $display("error at %0t ns: %s is %0b, expected %0b", $time, name, got, expected);
        end
    endtask

    task automatic expect_fields(input int got, input int want);
        if (got != want) begin
            other_errors++;
            $display("malformed line in the vectors file, %0d of %0d fields read", got, want);
        end
    endtask

    task automatic idle_cycles(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            din_valid <= 1'b0;
            sync_in <= 1'b0;
            cnt_rst <= 1'b0;
            rd_en <= 1'b0;
        end
    endtask

    // sync goes out with the first sample only
    task automatic drive_samples(input int reps, input cplx_pair_t s, input logic sy,
                                 input logic vld);
        for (int i = 0; i < reps; i++) begin
            @(posedge clk);
            din <= s;
            din_valid <= vld;
            sync_in <= sy && (i == 0);
            cnt_rst <= 1'b0;
            rd_en <= 1'b0;
        end
    endtask

    task automatic read_and_check(input sel_t sel, input chan_t addr, input acc_t expected);
        int waited;
        @(posedge clk);
        din_valid <= 1'b0;
        sync_in <= 1'b0;
        rd_en <= 1'b1;
        rd_sel <= sel;
        rd_addr <= addr;
        @(posedge clk);
        rd_en <= 1'b0;
        @(negedge clk);
        waited = 0;
        while (!rd_valid && waited < 4) begin
            @(negedge clk);
            waited++;
        end
        if (rd_valid) begin
            if (waited != 0) begin
                other_errors++;
                $display("read of channel %0d with sel %0d got rd_valid %0d cycles late",
                         addr, sel, waited);
            end
            check_acc($sformatf("rd_data (sel %0d, channel %0d)", sel, addr), rd_data, expected);
        end else begin
            other_errors++;
            $display("read of channel %0d with sel %0d never got rd_valid", addr, sel);
        end
    endtask

    initial begin
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run did not finish within %0d cycles", cycle_limit);
        $display("Something failed");
        $finish;
    end

    initial begin
        din = '0;
        din_valid = 1'b0;
        sync_in = 1'b0;
        acc_len = acc_len_t'(1);
        cnt_rst = 1'b0;
        rd_en = 1'b0;
        rd_addr = '0;
        rd_sel = sel_r11;
        reset = 1'b1;
        // four cycles per vector line on top of a fixed margin
        fd = $fopen("verif/correlator_vectors.txt", "r");
        if (fd != 0) begin
            while ($fgets(skip_line, fd) != 0) begin
                line_cnt++;
            end
            $fclose(fd);
        end
        cycle_limit = 4 * line_cnt + 200;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        fd = $fopen("verif/correlator_vectors.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("could not open verif/correlator_vectors.txt");
        end else begin
            while ($fscanf(fd, "%s", op) == 1) begin
                case (op)
                    "#": n = $fgets(skip_line, fd);
                    "s": begin
                        n = $fscanf(fd, "%d %d %d %d %d %d %d",
                                    count, v0, v1, v2, v3, sync, valid);
                        expect_fields(n, 7);
                        pair.x0_re = sample_t'(v0);
                        pair.x0_im = sample_t'(v1);
                        pair.x1_re = sample_t'(v2);
                        pair.x1_im = sample_t'(v3);
                        drive_samples(count, pair, sync != 0, valid != 0);
                    end
                    "l": begin
                        n = $fscanf(fd, "%d", v0);
                        expect_fields(n, 1);
                        @(posedge clk);
                        acc_len <= acc_len_t'(v0);
                        din_valid <= 1'b0;
                        sync_in <= 1'b0;
                    end
                    "c": begin
                        @(posedge clk);
                        cnt_rst <= 1'b1;
                        din_valid <= 1'b0;
                        sync_in <= 1'b0;
                        idle_cycles(1);
                    end
                    "w": begin
                        n = $fscanf(fd, "%d", count);
                        expect_fields(n, 1);
                        idle_cycles(count);
                    end
                    "r": begin
                        n = $fscanf(fd, "%d %d %d", v0, v1, v2);
                        expect_fields(n, 3);
                        read_and_check(sel_t'(v0), chan_t'(v1), acc_t'(v2));
                    end
                    "f": begin
                        n = $fscanf(fd, "%d %d", v0, v1);
                        expect_fields(n, 2);
                        @(negedge clk);
                        check_flag("data_ready", data_ready, v0 != 0);
                        check_flag("ovf_flag", ovf_flag, v1 != 0);
                    end
                    default: begin
                        other_errors++;
                        $display("unknown line type in the vectors file");
                    end
                endcase
            end
            $fclose(fd);
        end
        idle_cycles(4);
        $display("value errors: %0d, flag errors: %0d, other failures: %0d",
                 acc_errors, flag_errors, other_errors);
        if (acc_errors == 0 && flag_errors == 0 && other_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/correlator_top.sv
`timescale 1ns/1ps
`default_nettype none

module correlator_top (
    input wire clk,
    input wire reset,
    input wire corr_pkg::cplx_pair_t din,
    input wire din_valid,
    input wire sync_in,
    input wire corr_pkg::acc_len_t acc_len,
    input wire cnt_rst,
    input wire rd_en,
    input wire corr_pkg::chan_t rd_addr,
    input wire corr_pkg::sel_t rd_sel,
    output wire corr_pkg::acc_t rd_data,
    output wire rd_valid,
    output wire data_ready,
    output wire ovf_flag
);
    import corr_pkg::*;

    corr_result_t res;
    chan_t res_chan;
    logic res_valid;

    correlator_lane lane0 (
        .clk(clk),
        .reset(reset),
        .din(din),
        .din_valid(din_valid),
        .sync_in(sync_in),
        .acc_len(acc_len),
        .cnt_rst(cnt_rst),
        .res(res),
        .res_chan(res_chan),
        .res_valid(res_valid),
        .ovf_flag(ovf_flag)
    );

    // finished vectors land here for the host
    result_bank bank0 (
        .clk(clk),
        .reset(reset),
        .res(res),
        .res_chan(res_chan),
        .res_valid(res_valid),
        .rd_en(rd_en),
        .rd_addr(rd_addr),
        .rd_sel(rd_sel),
        .rd_data(rd_data),
        .rd_valid(rd_valid),
        .data_ready(data_ready)
    );

endmodule

`default_nettype wire

//--- logic/result_bank.sv
`timescale 1ns/1ps
`default_nettype none

module result_bank (
    input wire clk,
    input wire reset,
    input wire corr_pkg::corr_result_t res,
    input wire corr_pkg::chan_t res_chan,
    input wire res_valid,
    input wire rd_en,
    input wire corr_pkg::chan_t rd_addr,
    input wire corr_pkg::sel_t rd_sel,
    output corr_pkg::acc_t rd_data,
    output logic rd_valid,
    output logic data_ready
);
    import corr_pkg::*;

    // one memory per product, indexed by selector
    acc_t mem [4][vector_len];

    always_ff @(posedge clk) begin
        if (res_valid) begin
            mem[sel_r11][res_chan] <= res.r11;
            mem[sel_r22][res_chan] <= res.r22;
            mem[sel_r12_re][res_chan] <= res.r12_re;
            mem[sel_r12_im][res_chan] <= res.r12_im;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_sel][rd_addr];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;
        end
    end

    // set once the whole vector is in, cleared by a host read
    always_ff @(posedge clk) begin
        if (reset) begin
            data_ready <= 1'b0;
        end else if (res_valid && (res_chan == chan_t'(vector_len - 1))) begin
            data_ready <= 1'b1;
        end else if (rd_en) begin
            data_ready <= 1'b0;
        end
    end

    // lane only emits sums that started from a first frame
    res_known: assert property (
        @(posedge clk) disable iff (reset) res_valid |-> !$isunknown({res, res_chan})
    ) else $error("result written with unknown bits");

endmodule

`default_nettype wire

//--- logic/correlator_lane.sv
`timescale 1ns/1ps
`default_nettype none

module correlator_lane (
    input wire clk,
    input wire reset,
    input wire corr_pkg::cplx_pair_t din,
    input wire din_valid,
    input wire sync_in,
    input wire corr_pkg::acc_len_t acc_len,
    input wire cnt_rst,
    output wire corr_pkg::corr_result_t res,
    output wire corr_pkg::chan_t res_chan,
    output wire res_valid,
    output wire ovf_flag
);
    import corr_pkg::*;

    lane_tag_t tag;
    logic tag_valid;
    corr_prod_t prod;
    lane_tag_t prod_tag;
    logic prod_valid;

    frame_control frame_control0 (
        .clk(clk),
        .reset(reset),
        .din_valid(din_valid),
        .sync_in(sync_in),
        .acc_len(acc_len),
        .cnt_rst(cnt_rst),
        .tag(tag),
        .tag_valid(tag_valid)
    );

    // samples before the first sync are dropped here
    power_mult power_mult0 (
        .clk(clk),
        .reset(reset),
        .din(din),
        .din_valid(tag_valid),
        .tag(tag),
        .prod(prod),
        .prod_tag(prod_tag),
        .prod_valid(prod_valid)
    );

    vector_accumulator vector_accumulator0 (
        .clk(clk),
        .reset(reset),
        .prod(prod),
        .prod_tag(prod_tag),
        .prod_valid(prod_valid),
        .cnt_rst(cnt_rst),
        .res(res),
        .res_chan(res_chan),
        .res_valid(res_valid),
        .ovf_flag(ovf_flag)
    );

endmodule

`default_nettype wire

//--- logic/vector_accumulator.sv
`timescale 1ns/1ps
`default_nettype none

module vector_accumulator (
    input wire clk,
    input wire reset,
    input wire corr_pkg::corr_prod_t prod,
    input wire corr_pkg::lane_tag_t prod_tag,
    input wire prod_valid,
    input wire cnt_rst,
    output corr_pkg::corr_result_t res,
    output corr_pkg::chan_t res_chan,
    output logic res_valid,
    output logic ovf_flag
);
    import corr_pkg::*;

    // running sums, one entry per channel
    corr_result_t acc_mem [vector_len];

    corr_result_t base;
    corr_result_t addend;
    corr_result_t sum;
    logic [3:0] ovf_bits;

    // same-sign operands giving a result of the other sign
    function automatic logic add_ovf(input acc_t a, input acc_t b, input acc_t s);
        return (a[acc_width-1] == b[acc_width-1]) && (s[acc_width-1] != a[acc_width-1]);
    endfunction

    always_comb begin
        // first frame starts a fresh sum
        base = prod_tag.first ? '0 : acc_mem[prod_tag.chan];

        addend.r11 = acc_t'(prod.r11);
        addend.r22 = acc_t'(prod.r22);
        addend.r12_re = acc_t'(prod.r12_re);
        addend.r12_im = acc_t'(prod.r12_im);

        sum.r11 = base.r11 + addend.r11;
        sum.r22 = base.r22 + addend.r22;
        sum.r12_re = base.r12_re + addend.r12_re;
        sum.r12_im = base.r12_im + addend.r12_im;

        ovf_bits[0] = add_ovf(base.r11, addend.r11, sum.r11);
        ovf_bits[1] = add_ovf(base.r22, addend.r22, sum.r22);
        ovf_bits[2] = add_ovf(base.r12_re, addend.r12_re, sum.r12_re);
        ovf_bits[3] = add_ovf(base.r12_im, addend.r12_im, sum.r12_im);
    end

    always_ff @(posedge clk) begin
        if (prod_valid) begin
            acc_mem[prod_tag.chan] <= sum;
        end
    end

    // finished vector entry goes out on the last frame
    always_ff @(posedge clk) begin
        if (prod_valid && prod_tag.last) begin
            res <= sum;
            res_chan <= prod_tag.chan;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= prod_valid && prod_tag.last;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || cnt_rst) begin
            ovf_flag <= 1'b0;
        end else if (prod_valid && (|ovf_bits)) begin
            // sticky
            ovf_flag <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- logic/power_mult.sv
`timescale 1ns/1ps
`default_nettype none

module power_mult (
    input wire clk,
    input wire reset,
    input wire corr_pkg::cplx_pair_t din,
    input wire din_valid,
    input wire corr_pkg::lane_tag_t tag,
    output corr_pkg::corr_prod_t prod,
    output corr_pkg::lane_tag_t prod_tag,
    output logic prod_valid
);
    import corr_pkg::*;

    typedef logic signed [2*din_width-1:0] pprod_t;

    // x0 and x1 squares, then cross terms
    pprod_t p_r0r0;
    pprod_t p_i0i0;
    pprod_t p_r1r1;
    pprod_t p_i1i1;
    pprod_t p_r0r1;
    pprod_t p_i0i1;
    pprod_t p_i0r1;
    pprod_t p_r0i1;

    lane_tag_t tag_s1;
    logic valid_s1;

    always_ff @(posedge clk) begin
        if (din_valid) begin
            p_r0r0 <= din.x0_re * din.x0_re;
            p_i0i0 <= din.x0_im * din.x0_im;
            p_r1r1 <= din.x1_re * din.x1_re;
            p_i1i1 <= din.x1_im * din.x1_im;
            p_r0r1 <= din.x0_re * din.x1_re;
            p_i0i1 <= din.x0_im * din.x1_im;
            p_i0r1 <= din.x0_im * din.x1_re;
            p_r0i1 <= din.x0_re * din.x1_im;
            tag_s1 <= tag;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_s1) begin
            prod.r11 <= prod_t'(p_r0r0) + prod_t'(p_i0i0);
            prod.r22 <= prod_t'(p_r1r1) + prod_t'(p_i1i1);
            // x0 * conj(x1)
            prod.r12_re <= prod_t'(p_r0r1) + prod_t'(p_i0i1);
            prod.r12_im <= prod_t'(p_i0r1) - prod_t'(p_r0i1);
            prod_tag <= tag_s1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_s1 <= 1'b0;
            prod_valid <= 1'b0;
        end else begin
            valid_s1 <= din_valid;
            prod_valid <= valid_s1;
        end
    end

endmodule

`default_nettype wire

//--- logic/frame_control.sv
`timescale 1ns/1ps
`default_nettype none

module frame_control (
    input wire clk,
    input wire reset,
    input wire din_valid,
    input wire sync_in,
    input wire corr_pkg::acc_len_t acc_len,
    input wire cnt_rst,
    output corr_pkg::lane_tag_t tag,
    output logic tag_valid
);
    import corr_pkg::*;

    chan_t chan_cnt;
    acc_len_t frame_cnt;
    acc_len_t len_q;
    logic armed;

    chan_t cur_chan;
    acc_len_t cur_frame;
    acc_len_t cur_len;
    logic accept;

    always_comb begin
        // a sync sample is channel 0 of frame 0 already
        cur_chan = sync_in ? '0 : chan_cnt;
        cur_frame = sync_in ? '0 : frame_cnt;
        if (sync_in) begin
            // zero length behaves as one frame
            cur_len = (acc_len == '0) ? acc_len_t'(1) : acc_len;
        end else begin
            cur_len = len_q;
        end
        accept = din_valid && (armed || sync_in);

        tag.chan = cur_chan;
        tag.first = (cur_frame == '0);
        tag.last = (cur_frame == acc_len_t'(cur_len - 1'b1));
        tag_valid = accept;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            chan_cnt <= '0;
            frame_cnt <= '0;
            len_q <= acc_len_t'(1);
            armed <= 1'b0;
        end else if (cnt_rst) begin
            chan_cnt <= '0;
            frame_cnt <= '0;
            armed <= 1'b0;
        end else if (accept) begin
            armed <= 1'b1;
            if (sync_in) begin
                len_q <= cur_len;
            end
            if (cur_chan == chan_t'(vector_len - 1)) begin
                chan_cnt <= '0;
                // wrap so integrations run back to back
                if (tag.last) begin
                    frame_cnt <= '0;
                end else begin
                    frame_cnt <= cur_frame + 1'b1;
                end
            end else begin
                chan_cnt <= cur_chan + 1'b1;
            end
        end
    end

    sync_needs_valid: assert property (
        @(posedge clk) disable iff (reset) sync_in |-> din_valid
    ) else $error("sync_in seen without din_valid");

endmodule

`default_nettype wire

//--- logic/corr_pkg.sv
`default_nettype none

package corr_pkg;

    localparam int din_width = 8;
    localparam int vector_len = 8;
    localparam int acc_width = 32;

    // sum of two din x din products needs one extra bit
    localparam int prod_width = 2 * din_width + 1;
    localparam int chan_width = $clog2(vector_len);
    localparam int acc_len_width = 16;

    typedef logic signed [din_width-1:0] sample_t;
    typedef logic signed [prod_width-1:0] prod_t;
    typedef logic signed [acc_width-1:0] acc_t;
    typedef logic [chan_width-1:0] chan_t;
    typedef logic [acc_len_width-1:0] acc_len_t;

    // host read selector
    typedef enum logic [1:0] {
        sel_r11,
        sel_r22,
        sel_r12_re,
        sel_r12_im
    } sel_t;

    typedef struct packed {
        sample_t x0_re;
        sample_t x0_im;
        sample_t x1_re;
        sample_t x1_im;
    } cplx_pair_t;

    typedef struct packed {
        chan_t chan;
        logic first;
        logic last;
    } lane_tag_t;

    typedef struct packed {
        prod_t r11;
        prod_t r22;
        prod_t r12_re;
        prod_t r12_im;
    } corr_prod_t;

    typedef struct packed {
        acc_t r11;
        acc_t r22;
        acc_t r12_re;
        acc_t r12_im;
    } corr_result_t;

endpackage

`default_nettype wire
